//--- icache_pkg.sv
`default_nettype none

package icache_pkg;

    ////////////////////////////////////////
    // Geometry
    ////////////////////////////////////////

    localparam int NSET   = 256;
    localparam int NWAY   = 2;
    localparam int LINE_W = 128;
    localparam int WORD_W = 32;
    localparam int BEATS  = LINE_W / WORD_W;

    // Address split
    localparam int TAG_W = 20;
    localparam int IDX_W = 8;
    localparam int OFS_W = 4;

    ////////////////////////////////////////
    // Shared structs
    ////////////////////////////////////////

    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic [IDX_W-1:0] index;
        logic [OFS_W-1:0] offset;
    } icache_addr_t;

    typedef struct packed {
        logic         req;
        icache_addr_t addr;
    } fetch_req_t;

    typedef struct packed {
        logic              valid;
        logic [LINE_W-1:0] data;
    } fetch_rsp_t;

    // Offset of line_addr is always zero
    typedef struct packed {
        logic         valid;
        icache_addr_t line_addr;
    } refill_req_t;

    typedef struct packed {
        logic              done;
        logic [LINE_W-1:0] line;
    } refill_rsp_t;

    // Wishbone classic master side
    typedef struct packed {
        logic                           cyc;
        logic                           stb;
        logic                           we;
        logic [WORD_W/8-1:0]            sel;
        logic [TAG_W+IDX_W+OFS_W-1:0]   adr;
    } wb_req_t;

    typedef struct packed {
        logic              ack;
        logic [WORD_W-1:0] dat;
    } wb_rsp_t;

endpackage

`default_nettype wire

//--- icache_bram.sv
`default_nettype none

module icache_bram #(
    parameter int DATA_W = 32
) (
    input  wire logic                       clk,

    input  wire logic                       we_a_i,
    input  wire logic [icache_pkg::IDX_W-1:0] addr_a_i,
    input  wire logic [DATA_W-1:0]          wdata_a_i,
    output logic      [DATA_W-1:0]          rdata_a_o,

    input  wire logic                       we_b_i,
    input  wire logic [icache_pkg::IDX_W-1:0] addr_b_i,
    input  wire logic [DATA_W-1:0]          wdata_b_i,
    output logic      [DATA_W-1:0]          rdata_b_o
);

    import icache_pkg::*;

    logic [DATA_W-1:0] mem [NSET];

    // Read-first on both ports, old contents come out on a write
    always_ff @(posedge clk) begin
        if (we_a_i) begin
            mem[addr_a_i] <= wdata_a_i;
        end
        if (we_b_i) begin
            mem[addr_b_i] <= wdata_b_i;
        end
        rdata_a_o <= mem[addr_a_i];
        rdata_b_o <= mem[addr_b_i];
    end

endmodule

`default_nettype wire

//--- icache_refill.sv
`default_nettype none

module icache_refill (
    input  wire logic                    clk,
    input  wire logic                    rst_n,

    input  wire icache_pkg::refill_req_t refill_req_i,
    output icache_pkg::refill_rsp_t      refill_rsp_o,

    output icache_pkg::wb_req_t          wb_o,
    input  wire icache_pkg::wb_rsp_t     wb_i
);

    import icache_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_STROBE,
        ST_GAP,
        ST_DONE
    } state_t;

    state_t                     state_q;
    logic [$clog2(BEATS)-1:0]   beat_q;
    logic [LINE_W-1:0]          line_q;
    logic                       beat_ack;

    assign beat_ack = (state_q == ST_STROBE) && wb_i.ack;

    ////////////////////////////////////////
    // Beat sequencing
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
            beat_q  <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (refill_req_i.valid) begin
                        state_q <= ST_STROBE;
                        beat_q  <= '0;
                    end
                end
                ST_STROBE: begin
                    if (wb_i.ack) begin
                        beat_q <= beat_q + 1'b1;
                        // All ones marks the last beat
                        state_q <= (&beat_q) ? ST_DONE : ST_GAP;
                    end
                end
                ST_GAP: begin
                    state_q <= ST_STROBE;
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // Words enter at the top, so beat 0 ends up in the low slot
    always_ff @(posedge clk) begin
        if (beat_ack) begin
            line_q <= {wb_i.dat, line_q[LINE_W-1:WORD_W]};
        end
    end

    always_comb begin
        wb_o           = '0;
        wb_o.cyc       = (state_q == ST_STROBE) || (state_q == ST_GAP);
        wb_o.stb       = (state_q == ST_STROBE);
        wb_o.we        = 1'b0;
        wb_o.sel       = '1;
        wb_o.adr       = {refill_req_i.line_addr.tag, refill_req_i.line_addr.index,
                          beat_q, 2'b00};
    end

    assign refill_rsp_o.done = (state_q == ST_DONE);
    assign refill_rsp_o.line = line_q;

    ////////////////////////////////////////
    // Protocol checks
    ////////////////////////////////////////

    // Cyc holds from the first strobe until the last ack of the line
    a_cyc_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wb_o.cyc && !(beat_ack && (&beat_q)) |=> wb_o.cyc);

    // Request address must not move under a pending strobe
    a_adr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wb_o.stb && !wb_i.ack |=> wb_o.stb && $stable(wb_o.adr));

    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        refill_rsp_o.done |=> !refill_rsp_o.done);

endmodule

`default_nettype wire

//--- icache_core.sv
`default_nettype none

module icache_core (
    input  wire logic                    clk,
    input  wire logic                    rst_n,

    input  wire icache_pkg::fetch_req_t  fetch1_i,
    input  wire icache_pkg::fetch_req_t  fetch2_i,
    output icache_pkg::fetch_rsp_t       fetch1_o,
    output icache_pkg::fetch_rsp_t       fetch2_o,

    output icache_pkg::refill_req_t      refill_req_o,
    input  wire icache_pkg::refill_rsp_t refill_rsp_i
);

    import icache_pkg::*;

    // Index 0 is fetch port 1 and RAM port a, index 1 is port 2 and RAM port b
    fetch_req_t   [1:0]                         fetch_in;
    fetch_rsp_t   [1:0]                         fetch_out;

    logic         [1:0]                         req_q;
    icache_addr_t [1:0]                         addr_q;

    logic         [1:0]                         install;
    logic         [1:0][IDX_W-1:0]              ram_idx;
    logic         [1:0][NWAY-1:0]               ram_we;
    logic         [1:0][NWAY-1:0][TAG_W-1:0]    tag_rd;
    logic         [1:0][NWAY-1:0][LINE_W-1:0]   line_rd;
    logic         [1:0][NWAY-1:0]               way_hit;
    logic         [1:0]                         hit;
    logic         [1:0]                         miss;

    logic         [NWAY-1:0][NSET-1:0]          valid_q;
    logic                                       busy_q;
    logic                                       sel_q;
    logic                                       rr_q;
    icache_addr_t                               miss_addr_q;

    assign fetch_in[0] = fetch1_i;
    assign fetch_in[1] = fetch2_i;
    assign fetch1_o    = fetch_out[0];
    assign fetch2_o    = fetch_out[1];

    ////////////////////////////////////////
    // Tag and data RAMs
    ////////////////////////////////////////

    for (genvar w = 0; w < NWAY; w++) begin : g_way
        icache_bram #(
            .DATA_W (TAG_W)
        ) u_tag (
            .clk       (clk),
            .we_a_i    (ram_we[0][w]),
            .addr_a_i  (ram_idx[0]),
            .wdata_a_i (miss_addr_q.tag),
            .rdata_a_o (tag_rd[0][w]),
            .we_b_i    (ram_we[1][w]),
            .addr_b_i  (ram_idx[1]),
            .wdata_b_i (miss_addr_q.tag),
            .rdata_b_o (tag_rd[1][w])
        );

        icache_bram #(
            .DATA_W (LINE_W)
        ) u_data (
            .clk       (clk),
            .we_a_i    (ram_we[0][w]),
            .addr_a_i  (ram_idx[0]),
            .wdata_a_i (refill_rsp_i.line),
            .rdata_a_o (line_rd[0][w]),
            .we_b_i    (ram_we[1][w]),
            .addr_b_i  (ram_idx[1]),
            .wdata_b_i (refill_rsp_i.line),
            .rdata_b_o (line_rd[1][w])
        );
    end

    ////////////////////////////////////////
    // Lookup and hit
    ////////////////////////////////////////

    always_comb begin
        for (int p = 0; p < 2; p++) begin
            // Install goes through the missing port's RAM port
            install[p] = busy_q && refill_rsp_i.done && (sel_q == p[0]);
            ram_idx[p] = install[p] ? miss_addr_q.index : fetch_in[p].addr.index;

            fetch_out[p] = '0;
            for (int w = 0; w < NWAY; w++) begin
                ram_we[p][w]  = install[p] && (rr_q == w[0]);
                way_hit[p][w] = valid_q[w][addr_q[p].index]
                                && (tag_rd[p][w] == addr_q[p].tag);
                if (way_hit[p][w]) begin
                    fetch_out[p].data = line_rd[p][w];
                end
            end

            hit[p]             = req_q[p] && (|way_hit[p]);
            miss[p]            = req_q[p] && !(|way_hit[p]);
            fetch_out[p].valid = hit[p];
        end
    end

    // Drop the resample in the valid cycle and across an install edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_q <= '0;
        end else begin
            for (int p = 0; p < 2; p++) begin
                req_q[p] <= fetch_in[p].req && !hit[p] && !(|install);
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < 2; p++) begin
            addr_q[p] <= fetch_in[p].addr;
        end
    end

    ////////////////////////////////////////
    // Miss arbitration and install
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
            busy_q  <= 1'b0;
            sel_q   <= 1'b0;
            rr_q    <= 1'b0;
        end else if (busy_q) begin
            if (refill_rsp_i.done) begin
                busy_q                          <= 1'b0;
                valid_q[rr_q][miss_addr_q.index] <= 1'b1;
                rr_q                            <= ~rr_q;
            end
        end else if (|miss) begin
            // Port 1 first
            busy_q <= 1'b1;
            sel_q  <= !miss[0];
        end
    end

    always_ff @(posedge clk) begin
        if (!busy_q && (|miss)) begin
            miss_addr_q <= miss[0] ? addr_q[0] : addr_q[1];
        end
    end

    always_comb begin
        refill_req_o                  = '0;
        refill_req_o.valid            = busy_q;
        refill_req_o.line_addr.tag    = miss_addr_q.tag;
        refill_req_o.line_addr.index  = miss_addr_q.index;
    end

    // Valid only answers a request taken on the edge before
    a_valid1_req: assert property (@(posedge clk) disable iff (!rst_n)
        fetch1_o.valid |-> $past(fetch1_i.req));

    a_valid2_req: assert property (@(posedge clk) disable iff (!rst_n)
        fetch2_o.valid |-> $past(fetch2_i.req));

endmodule

`default_nettype wire

//--- icache_top.sv
`default_nettype none

module icache_top (
    input  wire logic                   clk,
    input  wire logic                   rst_n,

    input  wire icache_pkg::fetch_req_t fetch1_i,
    input  wire icache_pkg::fetch_req_t fetch2_i,
    output icache_pkg::fetch_rsp_t      fetch1_o,
    output icache_pkg::fetch_rsp_t      fetch2_o,

    output icache_pkg::wb_req_t         wb_o,
    input  wire icache_pkg::wb_rsp_t    wb_i
);

    import icache_pkg::*;

    refill_req_t refill_req;
    refill_rsp_t refill_rsp;

    icache_core u_core (
        .clk          (clk),
        .rst_n        (rst_n),
        .fetch1_i     (fetch1_i),
        .fetch2_i     (fetch2_i),
        .fetch1_o     (fetch1_o),
        .fetch2_o     (fetch2_o),
        .refill_req_o (refill_req),
        .refill_rsp_i (refill_rsp)
    );

    // Single outstanding line fill on the Wishbone side
    icache_refill u_refill (
        .clk          (clk),
        .rst_n        (rst_n),
        .refill_req_i (refill_req),
        .refill_rsp_o (refill_rsp),
        .wb_o         (wb_o),
        .wb_i         (wb_i)
    );

endmodule

`default_nettype wire

//--- tb_icache.sv
`default_nettype none

module tb_icache;

    import icache_pkg::*;

    localparam int PERIOD        = 40;
    localparam int STRESS_ROUNDS = 150;
    // Fetch requests over all tests, each port counted
    localparam int N_REQ         = 12 + 2 * STRESS_ROUNDS;

    localparam logic [31:0] LINE_A = 32'h00A0_0400;
    localparam logic [31:0] LINE_B = 32'h00B0_0408;
    localparam logic [31:0] LINE_C = 32'h00C0_0404;

    logic        clk = 1'b0;
    logic        rst_n = 1'b0;
    fetch_req_t  fetch1;
    fetch_req_t  fetch2;
    fetch_rsp_t  rsp1;
    fetch_rsp_t  rsp2;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp = '0;

    int          seed = 48;
    int          ack_seed = 48;
    int          ack_wait;
    bit          beat_pending;
    int          ack_count;
    logic [31:0] bus_log [$];

    // Reference cache: tags, valid bits, one round-robin bit
    logic [TAG_W-1:0] tag_m [NWAY][NSET];
    bit               val_m [NWAY][NSET];
    bit               rr_m;
    int               refills_total;

    int errors;
    int passed;
    int failed;

    always #(PERIOD / 2) clk = ~clk;

    icache_top dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .fetch1_i (fetch1),
        .fetch2_i (fetch2),
        .fetch1_o (rsp1),
        .fetch2_o (rsp2),
        .wb_o     (wb_req),
        .wb_i     (wb_rsp)
    );

    function automatic logic [31:0] mem_word(input logic [31:0] adr);
        return (adr * 32'h9E37_79B1) ^ {adr[15:0], adr[31:16]} ^ 32'h0F0F_5A5A;
    endfunction

    function automatic logic [LINE_W-1:0] line_of(input logic [31:0] a);
        logic [31:0] base;
        base = {a[31:4], 4'h0};
        return {mem_word(base + 32'd12), mem_word(base + 32'd8),
                mem_word(base + 32'd4), mem_word(base)};
    endfunction

    function automatic bit cached(input icache_addr_t a);
        return (val_m[0][a.index] && tag_m[0][a.index] == a.tag)
            || (val_m[1][a.index] && tag_m[1][a.index] == a.tag);
    endfunction

    function automatic void install_line(input icache_addr_t a);
        tag_m[rr_m][a.index] = a.tag;
        val_m[rr_m][a.index] = 1'b1;
        rr_m = !rr_m;
    endfunction

    ////////////////////////////////////////
    // Wishbone memory
    ////////////////////////////////////////

    always @(posedge clk) begin
        if (!rst_n) begin
            wb_rsp <= '0;
            beat_pending = 1'b0;
        end else begin
            wb_rsp.ack <= 1'b0;
            if (wb_req.cyc && wb_req.stb && !wb_rsp.ack) begin
                if (!beat_pending) begin
                    beat_pending = 1'b1;
                    ack_wait = $random(ack_seed) & 3;
                end
                if (ack_wait == 0) begin
                    wb_rsp.ack <= 1'b1;
                    wb_rsp.dat <= mem_word(wb_req.adr);
                    bus_log.push_back(wb_req.adr);
                    ack_count++;
                    beat_pending = 1'b0;
                end else begin
                    ack_wait--;
                end
            end
        end
    end

    ////////////////////////////////////////
    // Fetch helpers
    ////////////////////////////////////////

    task automatic check_line(input int port, input logic [31:0] a,
                              input logic [LINE_W-1:0] got);
        logic [LINE_W-1:0] exp;
        exp = line_of(a);
        assert (got == exp) else begin
            $display("MISMATCH t=%0t fetch%0d_o.data exp=%h got=%h", $time, port, exp, got);
            errors++;
        end
    endtask

    task automatic check_wb_ctrl(input int beats_done);
        if (wb_req.stb) begin
            assert (wb_req.we == 1'b0) else begin
                $display("MISMATCH t=%0t wb_o.we exp=0 got=%b", $time, wb_req.we);
                errors++;
            end
            assert (wb_req.sel == 4'hF) else begin
                $display("MISMATCH t=%0t wb_o.sel exp=f got=%h", $time, wb_req.sel);
                errors++;
            end
        end
        // Cyc stays high from the first to the last beat of a line
        assert (wb_req.cyc || beats_done % BEATS == 0) else begin
            $display("MISMATCH t=%0t wb_o.cyc exp=1 got=%b", $time, wb_req.cyc);
            errors++;
        end
    endtask

    task automatic fetch_pair(input bit en1, input logic [31:0] a1,
                              input bit en2, input logic [31:0] a2);
        bit hit1;
        bit hit2;
        bit done1;
        bit done2;
        int lat1;
        int lat2;
        int cyc;
        int refills;
        int acks0;
        hit1 = en1 && cached(a1);
        hit2 = en2 && cached(a2);
        refills = 0;
        // Port 1 refills first, port 2 looks up again after that install
        if (en1 && !hit1) begin
            install_line(a1);
            refills++;
        end
        if (en2 && !hit2 && !cached(a2)) begin
            install_line(a2);
            refills++;
        end
        refills_total += refills;
        acks0 = ack_count;
        done1 = !en1;
        done2 = !en2;
        cyc = 0;
        @(posedge clk);
        fetch1.req  <= en1;
        fetch1.addr <= a1;
        fetch2.req  <= en2;
        fetch2.addr <= a2;
        while (!(done1 && done2)) begin
            @(negedge clk);
            cyc++;
            check_wb_ctrl(ack_count - acks0);
            // A finished port must not see valid again
            assert (!(done1 && rsp1.valid) && !(done2 && rsp2.valid)) else begin
                $display("Valid raised at %0t on a port with no pending fetch", $time);
                errors++;
            end
            if (!done1 && rsp1.valid) begin
                check_line(1, a1, rsp1.data);
                lat1 = cyc;
                done1 = 1'b1;
            end
            if (!done2 && rsp2.valid) begin
                check_line(2, a2, rsp2.data);
                lat2 = cyc;
                done2 = 1'b1;
            end
            @(posedge clk);
            if (done1) begin
                fetch1.req <= 1'b0;
            end
            if (done2) begin
                fetch2.req <= 1'b0;
            end
        end
        // Hit answers in the cycle after the sampling edge
        assert (!hit1 || lat1 == 2) else begin
            $display("Port 1 hit at %0t answered after %0d cycles instead of 2", $time, lat1);
            errors++;
        end
        assert (!hit2 || lat2 == 2) else begin
            $display("Port 2 hit at %0t answered after %0d cycles instead of 2", $time, lat2);
            errors++;
        end
        assert (ack_count - acks0 == BEATS * refills) else begin
            $display("Wrong number of Wishbone acks at %0t: expected %0d, saw %0d",
                     $time, BEATS * refills, ack_count - acks0);
            errors++;
        end
    endtask

    task automatic check_adr(input int k, input logic [31:0] exp);
        assert (bus_log.size() > k && bus_log[k] == exp) else begin
            $display("MISMATCH t=%0t wb_o.adr beat %0d exp=%h got=%h", $time, k, exp,
                     (bus_log.size() > k) ? bus_log[k] : 32'hxxxx_xxxx);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int err0);
        if (errors == err0) begin
            passed++;
            $display("[%0t] %s: ok", $time, name);
        end else begin
            failed++;
            $display("[%0t] %s: %0d errors", $time, name, errors - err0);
        end
    endtask

    ////////////////////////////////////////
    // Tests
    ////////////////////////////////////////

    initial begin
        int          err0;
        int          acks0;
        int          refills0;
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] victim;
        logic [31:0] survivor;
        fetch1 = '0;
        fetch2 = '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        err0 = errors;
        bus_log.delete();
        fetch_pair(1'b1, 32'h1234_5104, 1'b0, '0);
        assert (bus_log.size() == BEATS) else begin
            $display("Cold miss made %0d Wishbone reads instead of 4", bus_log.size());
            errors++;
        end
        for (int k = 0; k < BEATS; k++) begin
            check_adr(k, 32'h1234_5100 + 4 * k);
        end
        report_test("cold miss", err0);

        err0 = errors;
        fetch_pair(1'b1, 32'h1234_5100, 1'b1, 32'h1234_510C);
        report_test("hit after refill", err0);

        err0 = errors;
        bus_log.delete();
        fetch_pair(1'b1, 32'h0003_0200, 1'b1, 32'h0004_0218);
        check_adr(0, 32'h0003_0200);
        check_adr(4, 32'h0004_0210);
        report_test("two port misses", err0);

        // A, B and C share set 0x40
        err0 = errors;
        fetch_pair(1'b1, LINE_A, 1'b0, '0);
        fetch_pair(1'b0, '0, 1'b1, LINE_B);
        fetch_pair(1'b1, LINE_A, 1'b1, LINE_B);
        victim   = {tag_m[rr_m][8'h40], 8'h40, 4'h0};
        survivor = {tag_m[!rr_m][8'h40], 8'h40, 4'h0};
        fetch_pair(1'b1, LINE_C, 1'b0, '0);
        acks0 = ack_count;
        fetch_pair(1'b1, survivor, 1'b1, victim);
        assert (ack_count - acks0 == BEATS) else begin
            $display("Evicted line %h refetch made %0d acks instead of 4",
                     victim, ack_count - acks0);
            errors++;
        end
        report_test("replacement", err0);

        err0 = errors;
        acks0 = ack_count;
        refills0 = refills_total;
        for (int i = 0; i < STRESS_ROUNDS; i++) begin
            r1 = $random(seed);
            r2 = $random(seed);
            fetch_pair(1'b1, {18'h00080, r1[1:0], 6'h20, r1[3:2], r1[7:4]},
                       1'b1, {18'h00080, r2[1:0], 6'h20, r2[3:2], r2[7:4]});
        end
        assert (ack_count - acks0 == BEATS * (refills_total - refills0)) else begin
            $display("Stress made %0d acks, model predicted %0d",
                     ack_count - acks0, BEATS * (refills_total - refills0));
            errors++;
        end
        report_test("random stress", err0);

        $display("Tests passed %0d, failed %0d, errors %0d", passed, failed, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        #(N_REQ * 40 * PERIOD);
        $display("Watchdog expired at %0t, a fetch never got its response", $time);
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
icache_pkg.sv
icache_bram.sv
icache_refill.sv
icache_core.sv
icache_top.sv
tb_icache.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the icache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_icache -f flist.f -o sim_icache
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out="$(./obj_dir/sim_icache)"
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q 'All tests passed!'; then
    exit 0
fi
exit 1
